// File: rtl/lc_pkg.sv
// shared definitions for the slave page-scan link controller
// state codes are fixed because the status register exposes them
package lc_pkg;

  // controller states
  typedef enum logic [3:0] {
    st_standby          = 4'd0,
    st_page_scan        = 4'd1,
    st_scan_1more       = 4'd2,
    st_resp_txid        = 4'd3,
    st_resp_rxfhs       = 4'd4,
    st_resp_fhsdone     = 4'd5,
    st_resp_ackfhs      = 4'd6,
    st_newslave         = 4'd7,
    st_newslave_ackpoll = 4'd8,
    st_conn_active      = 4'd9
  } lc_state_e;

  ////////////////////////////////////////////////////////////
  // timing
  localparam int CLK_PER_US         = 6;     // clk_6M cycles per us
  localparam int US_PER_SLOT        = 625;
  localparam int US_PER_HALF_SLOT   = 312;
  localparam int PAGE_RESP_TO_SLOTS = 8;     // slots in resp_rxfhs
  localparam int NEWCONN_TO_SLOTS   = 32;    // slots in newslave
  localparam int SLOT_CNT_W         = 16;

  ////////////////////////////////////////////////////////////
  // register map
  localparam int AXI_ADDR_W = 5;
  localparam int AXI_DATA_W = 32;

  localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 5'h00;
  localparam logic [AXI_ADDR_W-1:0] REG_INTERVAL = 5'h04;
  localparam logic [AXI_ADDR_W-1:0] REG_WINDOW   = 5'h08;
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS   = 5'h0C;

  localparam logic [SLOT_CNT_W-1:0] INTERVAL_RST = 16'd8;
  localparam logic [SLOT_CNT_W-1:0] WINDOW_RST   = 16'd2;
  localparam logic [1:0]            AXI_RESP_OKAY = 2'b00;

endpackage

// File: rtl/slot_timer.sv
// free running slot grid counted from reset release
// not aligned to any master clock so slot edges follow rstz only
`timescale 1ns/100ps
module slot_timer (
  input  logic clk_6M,
  input  logic rstz,
  output logic us_p,
  output logic slot_p,
  output logic half_slot_p
);
  import lc_pkg::*;

  logic [2:0] pre_cnt;  // cycles within the us
  logic [9:0] us_cnt;   // us within the slot

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      pre_cnt <= '0;
    else if (us_p)
      pre_cnt <= '0;
    else
      pre_cnt <= pre_cnt + 3'd1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      us_cnt <= '0;
    else if (slot_p)
      us_cnt <= '0;  // wrap at slot end
    else if (us_p)
      us_cnt <= us_cnt + 10'd1;
  end

  assign us_p        = (pre_cnt == 3'(CLK_PER_US - 1));
  assign slot_p      = us_p && (us_cnt == 10'(US_PER_SLOT - 1));
  assign half_slot_p = us_p && (us_cnt == 10'(US_PER_HALF_SLOT - 1));

  // both pulses come off one counter so they must never coincide
  a_slot_half_apart: assert property (
    @(posedge clk_6M) disable iff (!rstz) !(slot_p && half_slot_p));

endmodule

// File: rtl/lc_regs.sv
// AXI4-Lite register block for page-scan setup and status
// one write and one read outstanding at most and no byte strobes
// every access answers OKAY and unmapped reads return zero
`timescale 1ns/100ps
module lc_regs (
  input  logic                          clk_6M,
  input  logic                          rstz,
  input  logic [lc_pkg::AXI_ADDR_W-1:0] s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [lc_pkg::AXI_DATA_W-1:0] s_axil_wdata,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [lc_pkg::AXI_ADDR_W-1:0] s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [lc_pkg::AXI_DATA_W-1:0] s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  input  lc_pkg::lc_state_e             state,
  input  logic                          conn_done_p,
  output logic [lc_pkg::SLOT_CNT_W-1:0] scan_interval,
  output logic [lc_pkg::SLOT_CNT_W-1:0] scan_window,
  output logic                          scan_en
);
  import lc_pkg::*;

  logic                  aw_got, w_got;  // half of a write already taken
  logic [AXI_ADDR_W-1:0] awaddr_q;
  logic [AXI_DATA_W-1:0] wdata_q;
  logic                  aw_fire, w_fire, ar_fire, wr_do;
  logic                  aw_got_n, w_got_n, bvalid_n, rvalid_n;
  logic [AXI_ADDR_W-1:0] wr_addr;
  logic [AXI_DATA_W-1:0] wr_data, rd_word;

  ////////////////////////////////////////////////////////////
  // write channel
  assign aw_fire = s_axil_awvalid && s_axil_awready;
  assign w_fire  = s_axil_wvalid && s_axil_wready;
  assign wr_do   = (aw_got || aw_fire) && (w_got || w_fire);
  assign wr_addr = aw_got ? awaddr_q : s_axil_awaddr;
  assign wr_data = w_got ? wdata_q : s_axil_wdata;

  assign aw_got_n = !wr_do && (aw_got || aw_fire);
  assign w_got_n  = !wr_do && (w_got || w_fire);
  assign bvalid_n = wr_do || (s_axil_bvalid && !s_axil_bready);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      aw_got         <= 1'b0;
      w_got          <= 1'b0;
      s_axil_bvalid  <= 1'b0;
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
    end
    else
    begin
      aw_got         <= aw_got_n;
      w_got          <= w_got_n;
      s_axil_bvalid  <= bvalid_n;
      s_axil_awready <= !aw_got_n && !bvalid_n;  // hold off while b waits
      s_axil_wready  <= !w_got_n && !bvalid_n;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (aw_fire)
      awaddr_q <= s_axil_awaddr;
    if (w_fire)
      wdata_q <= s_axil_wdata;
  end

  // config registers
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      scan_interval <= INTERVAL_RST;
      scan_window   <= WINDOW_RST;
      scan_en       <= 1'b0;
    end
    else
    begin
      if (wr_do && wr_addr == REG_INTERVAL)
        scan_interval <= wr_data[SLOT_CNT_W-1:0];
      if (wr_do && wr_addr == REG_WINDOW)
        scan_window <= wr_data[SLOT_CNT_W-1:0];
      if (wr_do && wr_addr == REG_CTRL && wr_data[0])
        scan_en <= 1'b1;                            // enable beats cancel
      else if ((wr_do && wr_addr == REG_CTRL && wr_data[1]) || conn_done_p)
        scan_en <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read channel
  assign ar_fire  = s_axil_arvalid && s_axil_arready;
  assign rvalid_n = ar_fire || (s_axil_rvalid && !s_axil_rready);

  always_comb
  begin
    rd_word = '0;
    case (s_axil_araddr)
      REG_INTERVAL: rd_word[SLOT_CNT_W-1:0] = scan_interval;
      REG_WINDOW:   rd_word[SLOT_CNT_W-1:0] = scan_window;
      REG_STATUS:   rd_word[4:0] = {scan_en, state};
      default:      rd_word = '0;  // ctrl is write only
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      s_axil_rvalid  <= 1'b0;
      s_axil_arready <= 1'b0;
    end
    else
    begin
      s_axil_rvalid  <= rvalid_n;
      s_axil_arready <= !rvalid_n;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (ar_fire)
      s_axil_rdata <= rd_word;
  end

  assign s_axil_bresp = AXI_RESP_OKAY;
  assign s_axil_rresp = AXI_RESP_OKAY;

  a_bvalid_hold: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

endmodule

// File: rtl/page_scan_window.sv
// page-scan window timing in whole slots
// a window of length 0 still opens for one slot
`timescale 1ns/100ps
module page_scan_window (
  input  logic                          clk_6M,
  input  logic                          rstz,
  input  logic                          slot_p,
  input  logic                          scan_en,
  input  logic [lc_pkg::SLOT_CNT_W-1:0] scan_interval,
  input  logic [lc_pkg::SLOT_CNT_W-1:0] scan_window,
  input  logic                          extra_win_req,
  output logic                          scan_win
);
  import lc_pkg::*;

  logic                  running;     // interval grid started
  logic [SLOT_CNT_W-1:0] int_cnt;     // slots since window start
  logic [SLOT_CNT_W-1:0] win_cnt;     // slots the window has been open
  logic                  reg_win;
  logic                  extra_pend;
  logic [SLOT_CNT_W-1:0] extra_left;  // slots left in the extra window
  logic                  win_start;

  assign win_start = slot_p && scan_en && (!running || int_cnt == scan_interval - 1'b1);

  ////////////////////////////////////////////////////////////
  // periodic windows
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      running <= 1'b0;
      int_cnt <= '0;
      win_cnt <= '0;
      reg_win <= 1'b0;
    end
    else if (slot_p)
    begin
      if (!scan_en)
      begin
        running <= 1'b0;  // cancel closes on this slot
        reg_win <= 1'b0;
      end
      else if (win_start)
      begin
        running <= 1'b1;
        int_cnt <= '0;
        win_cnt <= {{(SLOT_CNT_W-1){1'b0}}, 1'b1};
        reg_win <= 1'b1;
      end
      else
      begin
        int_cnt <= int_cnt + 1'b1;
        if (reg_win && win_cnt >= scan_window)
          reg_win <= 1'b0;
        else if (reg_win)
          win_cnt <= win_cnt + 1'b1;
      end
    end
  end

  // one extra window after a response timeout
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      extra_pend <= 1'b0;
      extra_left <= '0;
    end
    else if (slot_p && (extra_pend || extra_win_req))
    begin
      extra_pend <= 1'b0;
      extra_left <= scan_window;
    end
    else
    begin
      if (extra_win_req)
        extra_pend <= 1'b1;
      if (slot_p && extra_left != '0)
        extra_left <= extra_left - 1'b1;
    end
  end

  assign scan_win = reg_win || (extra_left != '0);

  // a window only opens when enabled or on an extra request
  a_win_cause: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    $rose(scan_win) |-> $past(scan_en || extra_win_req || extra_pend));

endmodule

// File: rtl/page_resp_fsm.sv
// slave page response and new connection sequencing
// connection is left only through reset
// corr_hit fhs_good and poll_rx are single cycle pulses
`timescale 1ns/100ps
module page_resp_fsm (
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              slot_p,
  input  logic              half_slot_p,
  input  logic              scan_win,
  input  logic              scan_en,
  input  logic              corr_hit,
  input  logic              fhs_good,
  input  logic              poll_rx,
  output lc_pkg::lc_state_e state,
  output logic              ps,
  output logic              spr,
  output logic              conns,
  output logic              tx_start_p,
  output logic              extra_win_req,
  output logic              conn_done_p
);
  import lc_pkg::*;

  lc_state_e  next_state;
  logic       hit_q;     // id seen in the open window
  logic       poll_q;    // poll seen in newslave
  logic [5:0] to_cnt;    // slots in rxfhs or newslave
  logic       hit_now, poll_now, resp_to, conn_to;

  assign hit_now  = hit_q || (corr_hit && scan_win);
  assign poll_now = poll_q || poll_rx;
  assign resp_to  = slot_p && (to_cnt == 6'(PAGE_RESP_TO_SLOTS - 1));
  assign conn_to  = slot_p && (to_cnt == 6'(NEWCONN_TO_SLOTS - 1));

  ////////////////////////////////////////////////////////////
  // next state and pulse outputs
  always_comb
  begin
    next_state    = state;
    tx_start_p    = 1'b0;
    extra_win_req = 1'b0;
    conn_done_p   = 1'b0;
    case (state)
      st_standby:
        if (scan_win)
          next_state = st_page_scan;
      st_page_scan, st_scan_1more:
        if (slot_p && hit_now)
        begin
          next_state = st_resp_txid;
          tx_start_p = 1'b1;               // id reply
        end
        else if (!scan_win)
          next_state = st_standby;
      st_resp_txid:
        if (half_slot_p)
          next_state = st_resp_rxfhs;
      st_resp_rxfhs:
        if (fhs_good)
          next_state = st_resp_fhsdone;
        else if (resp_to)
        begin
          next_state    = st_scan_1more;
          extra_win_req = 1'b1;
        end
      st_resp_fhsdone:
        if (slot_p)
        begin
          next_state = st_resp_ackfhs;
          tx_start_p = 1'b1;               // id as fhs ack
        end
      st_resp_ackfhs:
        if (slot_p)
        begin
          next_state  = st_newslave;
          conn_done_p = 1'b1;
        end
      st_newslave:
        if (slot_p && poll_now)
        begin
          next_state = st_newslave_ackpoll;
          tx_start_p = 1'b1;               // null for the poll
        end
        else if (conn_to)
          next_state = st_page_scan;
      st_newslave_ackpoll:
        if (slot_p)
          next_state = st_conn_active;
      st_conn_active:
        next_state = st_conn_active;
      default:
        next_state = st_standby;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      state <= st_standby;
    else
      state <= next_state;
  end

  // shared timeout counter
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      to_cnt <= '0;
    else if (state != next_state)
      to_cnt <= '0;
    else if (slot_p && (state == st_resp_rxfhs || state == st_newslave))
      to_cnt <= to_cnt + 6'd1;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hit_q  <= 1'b0;
      poll_q <= 1'b0;
    end
    else
    begin
      if (!ps)
        hit_q <= 1'b0;
      else if (corr_hit && scan_win && scan_en)
        hit_q <= 1'b1;
      else if (corr_hit && scan_win && state == st_scan_1more)
        hit_q <= 1'b1;                     // extra window ignores scan_en
      if (state != st_newslave)
        poll_q <= 1'b0;
      else if (poll_rx)
        poll_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // grouped state flags
  assign ps    = (state == st_page_scan) || (state == st_scan_1more);
  assign spr   = (state == st_resp_txid) || (state == st_resp_rxfhs) ||
                 (state == st_resp_fhsdone) || (state == st_resp_ackfhs);
  assign conns = (state == st_newslave) || (state == st_newslave_ackpoll) ||
                 (state == st_conn_active);

  a_one_group: assert property (
    @(posedge clk_6M) disable iff (!rstz) $onehot0({ps, spr, conns}));

endmodule

// File: rtl/link_ctrl_top.sv
// slave link controller top with AXI4-Lite setup port
// correlator hit fhs decode and poll detect arrive as pulses
`timescale 1ns/100ps
module link_ctrl_top (
  input  logic                          clk_6M,
  input  logic                          rstz,
  input  logic [lc_pkg::AXI_ADDR_W-1:0] s_axil_awaddr,
  input  logic                          s_axil_awvalid,
  output logic                          s_axil_awready,
  input  logic [lc_pkg::AXI_DATA_W-1:0] s_axil_wdata,
  input  logic                          s_axil_wvalid,
  output logic                          s_axil_wready,
  output logic [1:0]                    s_axil_bresp,
  output logic                          s_axil_bvalid,
  input  logic                          s_axil_bready,
  input  logic [lc_pkg::AXI_ADDR_W-1:0] s_axil_araddr,
  input  logic                          s_axil_arvalid,
  output logic                          s_axil_arready,
  output logic [lc_pkg::AXI_DATA_W-1:0] s_axil_rdata,
  output logic [1:0]                    s_axil_rresp,
  output logic                          s_axil_rvalid,
  input  logic                          s_axil_rready,
  input  logic                          corr_hit,
  input  logic                          fhs_good,
  input  logic                          poll_rx,
  output logic                          ps,
  output logic                          spr,
  output logic                          conns,
  output logic                          tx_start_p
);
  import lc_pkg::*;

  logic                  slot_p, half_slot_p;
  logic [SLOT_CNT_W-1:0] scan_interval, scan_window;
  logic                  scan_en, scan_win;
  logic                  extra_win_req, conn_done_p;
  lc_state_e             state;

  slot_timer i_slot_timer (
    .clk_6M, .rstz,
    .us_p        (),  // us grid not needed by the slave path
    .slot_p, .half_slot_p
  );

  lc_regs i_lc_regs (
    .clk_6M, .rstz,
    .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
    .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .state, .conn_done_p,
    .scan_interval, .scan_window, .scan_en
  );

  page_scan_window i_page_scan_window (
    .clk_6M, .rstz, .slot_p, .scan_en,
    .scan_interval, .scan_window, .extra_win_req, .scan_win
  );

  page_resp_fsm i_page_resp_fsm (
    .clk_6M, .rstz, .slot_p, .half_slot_p, .scan_win, .scan_en,
    .corr_hit, .fhs_good, .poll_rx,
    .state, .ps, .spr, .conns, .tx_start_p, .extra_win_req, .conn_done_p
  );

endmodule

// File: dv/tb_link_ctrl.sv
// self-checking testbench for the slave link controller
// vectors come from dv/link_ctrl_vectors.txt, run from the project root
// hit time is jittered by up to 1000 cycles so hit offset plus 1000 must fit the window
`timescale 1ns/100ps
module tb_link_ctrl;
  import lc_pkg::*;

  localparam int SLOT_CYC = 3750;  // clk_6M cycles per slot

  logic        clk_6M = 1'b0;
  logic        rstz;
  logic [4:0]  s_axil_awaddr, s_axil_araddr;
  logic [31:0] s_axil_wdata, s_axil_rdata;
  logic        s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic [1:0]  s_axil_bresp, s_axil_rresp;
  logic        s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic        s_axil_rvalid, s_axil_rready;
  logic        corr_hit, fhs_good, poll_rx;
  logic        ps, spr, conns, tx_start_p;

  logic [15:0] vec [0:255];
  int          cyc = 0;
  int          limit = 0;
  int          rel_base = 0;  // cycle of reset release
  int          tx_cnt = 0;
  int          err_cnt = 0;
  int          chk_cnt = 0;

  link_ctrl_top i_dut (.*);

  always #4 clk_6M = ~clk_6M;

  always @(negedge clk_6M)
    if (rstz && tx_start_p)
      tx_cnt <= tx_cnt + 1;

  // run limit
  always @(posedge clk_6M)
  begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic apply_reset();
    rstz           = 1'b0;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    s_axil_arvalid = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_rready  = 1'b0;
    corr_hit       = 1'b0;
    fhs_good       = 1'b0;
    poll_rx        = 1'b0;
    repeat (3) @(negedge clk_6M);
    rstz     = 1'b1;
    rel_base = cyc;
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite master
  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
    logic aw_hs, w_hs, b_hs;
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    while (s_axil_awvalid || s_axil_wvalid)
    begin
      aw_hs = s_axil_awvalid && s_axil_awready;  // ready is registered
      w_hs  = s_axil_wvalid && s_axil_wready;
      @(negedge clk_6M);
      if (aw_hs)
        s_axil_awvalid = 1'b0;
      if (w_hs)
        s_axil_wvalid = 1'b0;
    end
    b_hs = 1'b0;
    while (!b_hs)
    begin
      b_hs = s_axil_bvalid;
      if (b_hs)
        check("write response", 32'(s_axil_bresp), 32'd0);
      @(negedge clk_6M);
    end
    s_axil_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
    logic ar_hs, r_hs;
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b1;
    ar_hs = 1'b0;
    while (!ar_hs)
    begin
      ar_hs = s_axil_arready;
      @(negedge clk_6M);
    end
    s_axil_arvalid = 1'b0;
    r_hs = 1'b0;
    while (!r_hs)
    begin
      r_hs = s_axil_rvalid;
      data = s_axil_rdata;
      if (r_hs)
        check("read response", 32'(s_axil_rresp), 32'd0);
      @(negedge clk_6M);
    end
    s_axil_rready = 1'b0;
  endtask

  initial
  begin
    int          n_tests, t, kind, v_int, v_win, v_hit, v_fhs, v_poll, v_exp, v_tx;
    int          err0, tx_base, t_rise, t_fall;
    logic        seen;
    logic [31:0] rd;
    s_axil_awaddr = '0;
    s_axil_araddr = '0;
    s_axil_wdata  = '0;
    rstz          = 1'b0;
    void'($urandom(32'hdb99a98a));
    for (int i = 0; i < 256; i++)
      vec[i] = 16'hffff;
    $readmemh("dv/link_ctrl_vectors.txt", vec);
    n_tests = 0;
    while (n_tests < 32 && vec[8*n_tests] != 16'hffff)
    begin
      limit   = limit + (32'(vec[8*n_tests+1]) + 40) * SLOT_CYC;
      n_tests = n_tests + 1;
    end

    for (t = 0; t < n_tests; t++)
    begin
      kind   = 32'(vec[8*t]);
      v_int  = 32'(vec[8*t+1]);
      v_win  = 32'(vec[8*t+2]);
      v_hit  = 32'(vec[8*t+3]);
      v_fhs  = 32'(vec[8*t+4]);
      v_poll = 32'(vec[8*t+5]);
      v_exp  = 32'(vec[8*t+6]);
      v_tx   = 32'(vec[8*t+7]);
      err0   = err_cnt;
      apply_reset();
      tx_base = tx_cnt;
      if (kind == 0)
      begin
        axi_read(REG_INTERVAL, rd);
        check("interval reset value", rd, 32'd8);
        axi_read(REG_WINDOW, rd);
        check("window reset value", rd, 32'd2);
        axi_read(REG_STATUS, rd);
        check("status reset value", rd, 32'd0);
      end
      axi_write(REG_INTERVAL, 32'(v_int));
      axi_write(REG_WINDOW, 32'(v_win));
      case (kind)
        0:
        begin
          axi_read(REG_INTERVAL, rd);
          check("interval readback", rd, 32'(v_int));
          axi_read(REG_WINDOW, rd);
          check("window readback", rd, 32'(v_win));
          axi_write(REG_CTRL, 32'd1);
          axi_read(REG_STATUS, rd);
          check("status after enable", rd, 32'h10);
          axi_write(REG_CTRL, 32'd2);
          axi_read(REG_STATUS, rd);
          check("status after cancel", rd, 32'h0);
          axi_read(5'h10, rd);
          check("unmapped read", rd, 32'h0);
        end
        1:
        begin
          axi_write(REG_CTRL, 32'd1);
          while (ps !== 1'b1) @(negedge clk_6M);
          t_rise = cyc - rel_base;
          check("ps rise one cycle after slot", 32'((t_rise - 1) % SLOT_CYC), 32'd0);
          while (ps !== 1'b0) @(negedge clk_6M);
          t_fall = cyc - rel_base;
          check("window length", 32'(t_fall - t_rise), 32'(v_win * SLOT_CYC));
          while (ps !== 1'b1) @(negedge clk_6M);
          check("window interval", 32'(cyc - rel_base - t_rise), 32'(v_int * SLOT_CYC));
        end
        2:
        begin
          axi_write(REG_CTRL, 32'd1);
          while (ps !== 1'b1) @(negedge clk_6M);
          repeat (v_hit + int'($urandom % 1000)) @(negedge clk_6M);
          corr_hit = 1'b1;
          @(negedge clk_6M);
          corr_hit = 1'b0;
          while (spr !== 1'b1) @(negedge clk_6M);
          if (v_fhs != 0)
          begin
            repeat (SLOT_CYC) @(negedge clk_6M);  // well inside resp_rxfhs
            fhs_good = 1'b1;
            @(negedge clk_6M);
            fhs_good = 1'b0;
            while (conns !== 1'b1) @(negedge clk_6M);
            t_rise = cyc;  // newslave entered
            if (v_poll != 0)
            begin
              repeat (500) @(negedge clk_6M);
              poll_rx = 1'b1;
              @(negedge clk_6M);
              poll_rx = 1'b0;
              repeat (3 * SLOT_CYC) @(negedge clk_6M);
              check("conns held in connection", 32'(conns), 32'd1);
            end
            else
            begin
              while (conns !== 1'b0) @(negedge clk_6M);
              check("newslave timeout length", 32'(cyc - t_rise), 32'(32 * SLOT_CYC));
              check("page scan after newslave timeout", 32'(ps), 32'd1);
              repeat (4) @(negedge clk_6M);
            end
            axi_read(REG_STATUS, rd);
            check("final status", rd, 32'(v_exp));  // enable cleared by connection
          end
          else
          begin
            while (spr !== 1'b0) @(negedge clk_6M);
            check("extra window after response timeout", 32'(ps), 32'd1);
            repeat (v_win * SLOT_CYC - 1) @(negedge clk_6M);
            check("ps held through the extra window", 32'(ps), 32'd1);
            repeat (2 * SLOT_CYC + 1) @(negedge clk_6M);
            axi_read(REG_STATUS, rd);
            check("scan enable kept", 32'(rd[4]), 32'd1);
            check("back in standby or page scan", 32'(rd[3:0] <= 4'd1), 32'd1);
          end
        end
        default:
        begin
          axi_write(REG_CTRL, 32'd1);
          while (ps !== 1'b1) @(negedge clk_6M);
          repeat (v_hit) @(negedge clk_6M);
          axi_write(REG_CTRL, 32'd2);
          t_rise = cyc;
          while (ps !== 1'b0) @(negedge clk_6M);
          check("cancel closes by next slot", 32'((cyc - t_rise) <= SLOT_CYC + 1), 32'd1);
          seen = 1'b0;
          repeat ((v_int + 1) * SLOT_CYC)
          begin
            @(negedge clk_6M);
            if (ps)
              seen = 1'b1;
          end
          check("no window after cancel", 32'(seen), 32'd0);
          axi_read(REG_STATUS, rd);
          check("status after cancel", rd, 32'(v_exp));
        end
      endcase
      check("tx_start count", 32'(tx_cnt - tx_base), 32'(v_tx));
      $display("test %0d kind %0d: %s", t, kind, (err_cnt == err0) ? "ok" : "failed");
    end

    $display("%0d tests, %0d checks, %0d errors", n_tests, chk_cnt, err_cnt);
    if (err_cnt == 0 && n_tests > 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: dv/link_ctrl_vectors.txt
// kind interval window hit_off fhs poll exp_state exp_tx, all hex
// kind 0 regs, 1 window cadence, 2 page response, 3 cancel; exp_state f means 0 or 1
0 5 3 0 0 0 0 0
1 4 2 0 0 0 0 0
1 6 1 0 0 0 0 0
2 4 2 64 1 1 9 3
2 5 1 c8 1 1 9 3
2 4 2 c8 0 0 f 1
2 4 2 64 1 0 0 2
3 5 2 1f4 0 0 0 0

// File: flist.f
rtl/lc_pkg.sv
rtl/slot_timer.sv
rtl/lc_regs.sv
rtl/page_scan_window.sv
rtl/page_resp_fsm.sv
rtl/link_ctrl_top.sv
dv/tb_link_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the link controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_link_ctrl \
  -f flist.f -o sim_link_ctrl
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_link_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "$out" | grep -q -F -x '** PASS **' || exit 1
exit 0
